//--- verilog/ifu_cfg.svh
////////////////////////////////////////////////////////////////////////////
// Instruction fetch unit configuration
// Widths, reset vector default and sequential PC increments
////////////////////////////////////////////////////////////////////////////
`ifndef IFU_CFG_SVH
`define IFU_CFG_SVH

// Address and instruction widths
`define IFU_PC_SIZE       32
`define IFU_INSTR_SIZE    32

// PC register value while rst_n is low
// The first fetch still comes from pc_rtvec
`define IFU_RTVEC_DEFAULT 32'h0000_0080

// Sequential step for a 32-bit and a 16-bit instruction
`define IFU_PC_INCR_RV32  4
`define IFU_PC_INCR_RV16  2

`endif

//--- verilog/rv_isa_pkg.sv
////////////////////////////////////////////////////////////////////////////
// RV32IC instruction set definitions
// Instruction word, immediate and the opcodes the fetch stage decodes
////////////////////////////////////////////////////////////////////////////
`include "ifu_cfg.svh"

package rv_isa_pkg;

  // Register width of the core, also the immediate width
  localparam int unsigned XLEN = 32;

  // Raw instruction word as returned by the fetch port
  typedef logic [`IFU_INSTR_SIZE-1:0] instr_t;

  // Sign-extended immediate, ready to be added to a PC
  typedef logic [XLEN-1:0] imm_t;

  // Major opcode field, bits 6:0 of a 32-bit instruction
  typedef logic [6:0] opcode_t;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes of interest to the predictor

  // Conditional branches BEQ/BNE/BLT/BGE/BLTU/BGEU
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  // Unconditional jump and link
  localparam opcode_t OPC_JAL    = 7'b1101111;

endpackage

//--- verilog/ifu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Fetch unit definitions
// PC type and the next-PC source select
////////////////////////////////////////////////////////////////////////////
`include "ifu_cfg.svh"

package ifu_pkg;

  // Fetch address
  typedef logic [`IFU_PC_SIZE-1:0] pc_t;

  // Next-PC source, listed in priority order
  typedef enum logic [2:0] {
    // Flush operands from the pipeline
    PC_SRC_FLUSH     = 3'd0,
    // Flush already stored in pc_r, hold it
    PC_SRC_DLY_FLUSH = 3'd1,
    // Predicted taken branch or JAL
    PC_SRC_BRANCH    = 3'd2,
    // First fetch after reset
    PC_SRC_RESET     = 3'd3,
    // PC plus instruction length
    PC_SRC_SEQ       = 3'd4
  } pc_src_e;

endpackage

//--- verilog/ifu_minidec.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// Fetch mini-decoder
// Instruction length, branch and jump class, and the B/J immediate
////////////////////////////////////////////////////////////////////////////

module ifu_minidec (
  input  rv_isa_pkg::instr_t instr,
  output logic               rv32,
  output logic               bxx,
  output logic               jal,
  output rv_isa_pkg::imm_t   bjp_imm
);

  rv_isa_pkg::opcode_t opcode;
  rv_isa_pkg::imm_t    imm_b;
  rv_isa_pkg::imm_t    imm_j;

  // Both low bits set means a full 32-bit encoding
  assign rv32   = (instr[1:0] == 2'b11);
  assign opcode = instr[6:0];

  // Only 32-bit forms are classified
  // Compressed jumps and branches run as sequential code
  assign bxx = rv32 & (opcode == rv_isa_pkg::OPC_BRANCH);
  assign jal = rv32 & (opcode == rv_isa_pkg::OPC_JAL);

  ////////////////////////////////////////////////////////////////////////////
  // Immediates

  // B-type: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
  assign imm_b = {{19{instr[31]}},
                  instr[31],
                  instr[7],
                  instr[30:25],
                  instr[11:8],
                  1'b0};

  // J-type: imm[20|10:1|11|19:12] in 31:12
  assign imm_j = {{11{instr[31]}},
                  instr[31],
                  instr[19:12],
                  instr[20],
                  instr[30:21],
                  1'b0};

  // The predictor only looks at this when bxx or jal is set
  assign bjp_imm = jal ? imm_j : imm_b;

endmodule

//--- verilog/ifu_litebpu.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// Static branch predictor
// JAL always taken, backward conditional branch taken
////////////////////////////////////////////////////////////////////////////

module ifu_litebpu (
  input  ifu_pkg::pc_t     pc,
  input  logic             bxx,
  input  logic             jal,
  input  rv_isa_pkg::imm_t bjp_imm,
  output logic             prdt_taken,
  output ifu_pkg::pc_t     prdt_pc_add_op1,
  output ifu_pkg::pc_t     prdt_pc_add_op2
);

  logic backward;

  // Negative offset, usually a loop closing branch
  assign backward = bjp_imm[rv_isa_pkg::XLEN-1];

  // Forward branches fall through
  assign prdt_taken = jal | (bxx & backward);

  ////////////////////////////////////////////////////////////////////////////
  // Target adder operands

  // Base is the PC of the instruction being decoded
  assign prdt_pc_add_op1 = pc;
  // PC relative offset, same width as the PC
  assign prdt_pc_add_op2 = ifu_pkg::pc_t'(bjp_imm);

endmodule

//--- verilog/ifu_fetch_ctrl.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// Fetch control
// Request issue, outstanding tracking, delayed flush, halt handshake,
// IR valid flags and next-PC source selection
////////////////////////////////////////////////////////////////////////////

module ifu_fetch_ctrl (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             ifu_req_ready,
  input  logic             ifu_rsp_valid,
  input  logic             ifu_o_ready,
  input  logic             pipe_flush_req,
  input  logic             ifu_halt_req,
  input  logic             prdt_taken,
  output logic             ifu_req_valid,
  output logic             ifu_rsp_ready,
  output logic             ifu_o_valid,
  output logic             ifu_o_pc_vld,
  output logic             ifu_halt_ack,
  output logic             pc_ena,
  output logic             ir_load,
  output logic             ir_pc_load,
  output ifu_pkg::pc_src_e pc_src
);

  // Next state of a set/clear flag, set wins
  function automatic logic flag_nxt(input logic q, input logic set, input logic clr);
    return set | (q & ~clr);
  endfunction

  logic reset_flag;
  logic reset_req;
  logic out_flag;
  logic dly_flush;
  logic ir_valid;
  logic ir_pc_vld;
  logic pc_newpend;
  logic halt_ack;

  logic req_hsk;
  logic rsp_hsk;
  logic ir_o_hsk;
  logic flush_real;
  logic new_req;
  logic new_req_condi;
  logic no_outs;
  logic ir_i_ready;
  logic ir_valid_set;
  logic ir_valid_clr;
  logic ir_pc_vld_set;
  logic bjp_req;

  assign req_hsk  = ifu_req_valid & ifu_req_ready;
  assign rsp_hsk  = ifu_rsp_valid & ifu_rsp_ready;
  assign ir_o_hsk = ir_valid & ifu_o_ready;

  // Live flush or one still waiting for the fetch port
  assign flush_real = pipe_flush_req | dly_flush;

  ////////////////////////////////////////////////////////////////////////////
  // Request and response channels

  // Normal fetching is off during the reset cycle and under halt
  assign new_req = ~ifu_halt_req & ~reset_flag;
  // Slot free, or the outstanding one returns this cycle
  assign new_req_condi = ~out_flag | rsp_hsk;
  assign ifu_req_valid = (new_req | reset_req | flush_real) & new_req_condi;

  // IR empty or being drained this cycle
  assign ir_i_ready = ~ir_valid | ir_valid_clr;
  // Responses under a flush are taken and dropped
  // Otherwise wait until the follow-on request can go out in the same cycle
  assign ifu_rsp_ready = flush_real | (ir_i_ready & ifu_req_ready & ~ifu_halt_req);

  // PC moves on a request or on every flush
  assign pc_ena = req_hsk | pipe_flush_req;

  // A returned response counts as done for halt purposes
  assign no_outs = ~out_flag | ifu_rsp_valid;

  ////////////////////////////////////////////////////////////////////////////
  // IR valid flags

  assign ir_valid_set  = rsp_hsk & ~flush_real;
  assign ir_valid_clr  = ir_o_hsk | (pipe_flush_req & ir_valid);
  // IR PC follows pc_r once the IR has room for it
  assign ir_pc_vld_set = pc_newpend & ir_i_ready & ~flush_real;

  assign ir_load      = ir_valid_set;
  assign ir_pc_load   = ir_pc_vld_set;
  assign ifu_o_valid  = ir_valid;
  assign ifu_o_pc_vld = ir_pc_vld;
  assign ifu_halt_ack = halt_ack;

  ////////////////////////////////////////////////////////////////////////////
  // Next-PC source

  // Prediction only counts with a real response on the port
  assign bjp_req = prdt_taken & ifu_rsp_valid;

  always_comb begin
    if (pipe_flush_req) begin
      pc_src = ifu_pkg::PC_SRC_FLUSH;
    end else if (dly_flush) begin
      pc_src = ifu_pkg::PC_SRC_DLY_FLUSH;
    end else if (bjp_req) begin
      pc_src = ifu_pkg::PC_SRC_BRANCH;
    end else if (reset_req) begin
      pc_src = ifu_pkg::PC_SRC_RESET;
    end else begin
      pc_src = ifu_pkg::PC_SRC_SEQ;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control flags

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reset_flag <= 1'b1;
      reset_req  <= 1'b0;
      out_flag   <= 1'b0;
      dly_flush  <= 1'b0;
      ir_valid   <= 1'b0;
      ir_pc_vld  <= 1'b0;
      pc_newpend <= 1'b0;
      halt_ack   <= 1'b0;
    end else begin
      // High for one cycle after reset release, kicks off the reset fetch
      reset_flag <= 1'b0;
      reset_req  <= flag_nxt(reset_req, reset_flag & ~reset_req, reset_req & req_hsk);
      out_flag   <= flag_nxt(out_flag, req_hsk, rsp_hsk);
      // Flush that could not reach the fetch port yet
      dly_flush  <= flag_nxt(dly_flush, pipe_flush_req & ~req_hsk, dly_flush & req_hsk);
      ir_valid   <= flag_nxt(ir_valid, ir_valid_set, ir_valid_clr);
      ir_pc_vld  <= flag_nxt(ir_pc_vld, ir_pc_vld_set, ir_valid_clr);
      pc_newpend <= flag_nxt(pc_newpend, pc_ena, ir_pc_vld_set);
      halt_ack   <= flag_nxt(halt_ack, ifu_halt_req & ~halt_ack & no_outs,
                             halt_ack & ~ifu_halt_req);
    end
  end

endmodule

//--- verilog/ifu_pc_gen.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// Next-PC generation
// Operand select, single adder and the fetch PC register
////////////////////////////////////////////////////////////////////////////
`include "ifu_cfg.svh"

module ifu_pc_gen (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             pc_ena,
  input  ifu_pkg::pc_src_e pc_src,
  input  ifu_pkg::pc_t     pc_rtvec,
  input  ifu_pkg::pc_t     pipe_flush_add_op1,
  input  ifu_pkg::pc_t     pipe_flush_add_op2,
  input  ifu_pkg::pc_t     prdt_pc_add_op1,
  input  ifu_pkg::pc_t     prdt_pc_add_op2,
  input  logic             rv32,
  output ifu_pkg::pc_t     pc_nxt,
  output ifu_pkg::pc_t     pc_r
);

  ifu_pkg::pc_t add_op1;
  ifu_pkg::pc_t add_op2;
  ifu_pkg::pc_t pc_incr;
  ifu_pkg::pc_t pc_sum;

  // Step by the length of the instruction just returned
  assign pc_incr = rv32 ? ifu_pkg::pc_t'(`IFU_PC_INCR_RV32) : ifu_pkg::pc_t'(`IFU_PC_INCR_RV16);

  // One adder shared by every source
  always_comb begin
    case (pc_src)
      ifu_pkg::PC_SRC_FLUSH: begin
        add_op1 = pipe_flush_add_op1;
        add_op2 = pipe_flush_add_op2;
      end
      ifu_pkg::PC_SRC_DLY_FLUSH: begin
        // Flush target was stored in pc_r when the flush came in
        add_op1 = pc_r;
        add_op2 = '0;
      end
      ifu_pkg::PC_SRC_BRANCH: begin
        add_op1 = prdt_pc_add_op1;
        add_op2 = prdt_pc_add_op2;
      end
      ifu_pkg::PC_SRC_RESET: begin
        add_op1 = pc_rtvec;
        add_op2 = '0;
      end
      default: begin
        // Sequential
        add_op1 = pc_r;
        add_op2 = pc_incr;
      end
    endcase
  end

  assign pc_sum = add_op1 + add_op2;
  // Halfword aligned for RV32C
  assign pc_nxt = {pc_sum[`IFU_PC_SIZE-1:1], 1'b0};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_r <= `IFU_RTVEC_DEFAULT;
    end else if (pc_ena) begin
      pc_r <= pc_nxt;
    end
  end

endmodule

//--- verilog/ifu_ir_stage.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// IR stage register
// Instruction, PC, bus error and prediction toward the execute stage
////////////////////////////////////////////////////////////////////////////

module ifu_ir_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ir_load,
  input  logic               ir_pc_load,
  input  rv_isa_pkg::instr_t instr,
  input  logic               rsp_err,
  input  logic               prdt_taken,
  input  ifu_pkg::pc_t       pc_r,
  output rv_isa_pkg::instr_t ifu_o_ir,
  output ifu_pkg::pc_t       ifu_o_pc,
  output logic               ifu_o_buserr,
  output logic               ifu_o_prdt_taken
);

  // Wide payload, qualified by the valid flags in the control block
  always_ff @(posedge clk) begin
    if (ir_load) begin
      ifu_o_ir <= instr;
    end
    // PC may arrive ahead of its instruction
    if (ir_pc_load) begin
      ifu_o_pc <= pc_r;
    end
  end

  // Status bits travel with the instruction
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ifu_o_buserr     <= 1'b0;
      ifu_o_prdt_taken <= 1'b0;
    end else if (ir_load) begin
      ifu_o_buserr     <= rsp_err;
      ifu_o_prdt_taken <= prdt_taken;
    end
  end

endmodule

//--- verilog/ifu_ifetch.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// Instruction fetch stage top
// Control, PC generation, mini-decode, static prediction and IR register
////////////////////////////////////////////////////////////////////////////

module ifu_ifetch (
  input  logic               clk,
  input  logic               rst_n,
  input  ifu_pkg::pc_t       pc_rtvec,
  // Fetch request
  output logic               ifu_req_valid,
  input  logic               ifu_req_ready,
  output ifu_pkg::pc_t       ifu_req_pc,
  // Fetch response
  input  logic               ifu_rsp_valid,
  output logic               ifu_rsp_ready,
  input  rv_isa_pkg::instr_t ifu_rsp_instr,
  input  logic               ifu_rsp_err,
  // IR toward execute
  output logic               ifu_o_valid,
  input  logic               ifu_o_ready,
  output rv_isa_pkg::instr_t ifu_o_ir,
  output ifu_pkg::pc_t       ifu_o_pc,
  output logic               ifu_o_pc_vld,
  output logic               ifu_o_prdt_taken,
  output logic               ifu_o_buserr,
  // Pipeline flush
  input  logic               pipe_flush_req,
  output logic               pipe_flush_ack,
  input  ifu_pkg::pc_t       pipe_flush_add_op1,
  input  ifu_pkg::pc_t       pipe_flush_add_op2,
  // Halt
  input  logic               ifu_halt_req,
  output logic               ifu_halt_ack
);

  logic             pc_ena;
  logic             ir_load;
  logic             ir_pc_load;
  ifu_pkg::pc_src_e pc_src;
  logic             rv32;
  logic             bxx;
  logic             jal;
  rv_isa_pkg::imm_t bjp_imm;
  logic             prdt_taken;
  ifu_pkg::pc_t     prdt_pc_add_op1;
  ifu_pkg::pc_t     prdt_pc_add_op2;
  ifu_pkg::pc_t     pc_nxt;
  ifu_pkg::pc_t     pc_r;

  // Flush never stalls, a late one is held inside the control block
  assign pipe_flush_ack = 1'b1;
  assign ifu_req_pc     = pc_nxt;

  ifu_fetch_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .ifu_req_ready  (ifu_req_ready),
    .ifu_rsp_valid  (ifu_rsp_valid),
    .ifu_o_ready    (ifu_o_ready),
    .pipe_flush_req (pipe_flush_req),
    .ifu_halt_req   (ifu_halt_req),
    .prdt_taken     (prdt_taken),
    .ifu_req_valid  (ifu_req_valid),
    .ifu_rsp_ready  (ifu_rsp_ready),
    .ifu_o_valid    (ifu_o_valid),
    .ifu_o_pc_vld   (ifu_o_pc_vld),
    .ifu_halt_ack   (ifu_halt_ack),
    .pc_ena         (pc_ena),
    .ir_load        (ir_load),
    .ir_pc_load     (ir_pc_load),
    .pc_src         (pc_src)
  );

  ifu_pc_gen u_pc_gen (
    .clk                (clk),
    .rst_n              (rst_n),
    .pc_ena             (pc_ena),
    .pc_src             (pc_src),
    .pc_rtvec           (pc_rtvec),
    .pipe_flush_add_op1 (pipe_flush_add_op1),
    .pipe_flush_add_op2 (pipe_flush_add_op2),
    .prdt_pc_add_op1    (prdt_pc_add_op1),
    .prdt_pc_add_op2    (prdt_pc_add_op2),
    .rv32               (rv32),
    .pc_nxt             (pc_nxt),
    .pc_r               (pc_r)
  );

  // Decodes the response word directly, before it reaches the IR
  ifu_minidec u_minidec (
    .instr   (ifu_rsp_instr),
    .rv32    (rv32),
    .bxx     (bxx),
    .jal     (jal),
    .bjp_imm (bjp_imm)
  );

  // pc_r holds the address of the instruction now on the response port
  ifu_litebpu u_litebpu (
    .pc              (pc_r),
    .bxx             (bxx),
    .jal             (jal),
    .bjp_imm         (bjp_imm),
    .prdt_taken      (prdt_taken),
    .prdt_pc_add_op1 (prdt_pc_add_op1),
    .prdt_pc_add_op2 (prdt_pc_add_op2)
  );

  ifu_ir_stage u_ir_stage (
    .clk              (clk),
    .rst_n            (rst_n),
    .ir_load          (ir_load),
    .ir_pc_load       (ir_pc_load),
    .instr            (ifu_rsp_instr),
    .rsp_err          (ifu_rsp_err),
    .prdt_taken       (prdt_taken),
    .pc_r             (pc_r),
    .ifu_o_ir         (ifu_o_ir),
    .ifu_o_pc         (ifu_o_pc),
    .ifu_o_buserr     (ifu_o_buserr),
    .ifu_o_prdt_taken (ifu_o_prdt_taken)
  );

endmodule

//--- sim/tb_ifu_tasks.svh
////////////////////////////////////////////////////////////////////////////
// Fetch stage directed tests
// Memory helpers, value check, bounded waits and one task per behavior
////////////////////////////////////////////////////////////////////////////
`ifndef TB_IFU_TASKS_SVH
`define TB_IFU_TASKS_SVH

// Background OP-IMM word built from the whole address
function automatic logic [31:0] fill_word(input logic [31:0] a);
  return {a[24:0] ^ {7'h0, a[31:14]}, 7'b0010011};
endfunction

function automatic logic [31:0] rd_word(input logic [31:0] a);
  if (a < 2 * MEM_DEPTH) begin
    return mem_word[a >> 1];
  end
  return fill_word(a);
endfunction

function automatic logic rd_err(input logic [31:0] a);
  if (a < 2 * MEM_DEPTH) begin
    return mem_err[a >> 1];
  end
  return 1'b0;
endfunction

// Both low bits set marks a 32-bit instruction
function automatic logic [31:0] step_of(input logic [31:0] w);
  return (w[1:0] == 2'b11) ? 32'd4 : 32'd2;
endfunction

// B-type BNE/BEQ x1, x2 and J-type JAL x1
function automatic logic [31:0] enc_branch(input logic [12:0] imm, input logic [2:0] f3);
  return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_jal(input logic [20:0] imm);
  return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
endfunction

task automatic init_memory();
  for (int i = 0; i < MEM_DEPTH; i++) begin
    mem_word[i] = fill_word(32'(i) << 1);
    mem_err[i]  = 1'b0;
  end
endtask

task automatic present_rsp(input logic [31:0] a);
  ifu_rsp_valid = 1'b1;
  ifu_rsp_instr = rd_word(a);
  ifu_rsp_err   = rd_err(a);
endtask

task automatic stop_fail();
  $display("TEST RESULT: FAIL");
  $fatal(1, "stopped at first error");
endtask

task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
  if (exp !== act) begin
    $display("ERR %s expected %h actual %h", name, exp, act);
    stop_fail();
  end
endtask

// Consume one IR entry and return 1 ns after the handshake edge
task automatic get_ir(input string name, output logic [31:0] ir, output logic [31:0] pc,
                      output logic err, output logic prdt);
  int unsigned n;
  n = 0;
  ifu_o_ready = 1'b1;
  @(negedge clk);
  while (!ifu_o_valid) begin
    n++;
    if (n > TIMEOUT) begin
      $display("Timed out waiting for an IR entry in %s", name);
      stop_fail();
    end
    @(negedge clk);
  end
  check_val({name, " pc_vld"}, 1, ifu_o_pc_vld);
  ir   = ifu_o_ir;
  pc   = ifu_o_pc;
  err  = ifu_o_buserr;
  prdt = ifu_o_prdt_taken;
  @(posedge clk);
  #1;
  ifu_o_ready = 1'b0;
endtask

// Wait for a held IR entry without consuming it
task automatic wait_o_valid(input string name);
  int unsigned n;
  n = 0;
  @(negedge clk);
  while (!ifu_o_valid) begin
    n++;
    if (n > TIMEOUT) begin
      $display("Timed out waiting for a held IR entry in %s", name);
      stop_fail();
    end
    @(negedge clk);
  end
endtask

task automatic apply_flush(input logic [31:0] op1, input logic [31:0] op2);
  pipe_flush_req     = 1'b1;
  pipe_flush_add_op1 = op1;
  pipe_flush_add_op2 = op2;
  @(posedge clk);
  #1;
  pipe_flush_req = 1'b0;
endtask

// Consume one entry and compare it with the expected fetch
task automatic expect_ir(input string name, input logic [31:0] pc_exp, input logic prdt_exp,
                         input logic err_exp);
  logic [31:0] ir;
  logic [31:0] pc;
  logic        err;
  logic        prdt;
  get_ir(name, ir, pc, err, prdt);
  check_val({name, " pc"}, pc_exp, pc);
  check_val({name, " ir"}, rd_word(pc_exp), ir);
  check_val({name, " prdt"}, prdt_exp, prdt);
  check_val({name, " buserr"}, err_exp, err);
  // Base for the next sequential step
  last_pc = pc_exp;
  last_ir = rd_word(pc_exp);
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests

task automatic reset_vector_fetch();
  @(negedge clk);
  check_val("reset o_valid", 0, ifu_o_valid);
  check_val("reset pc_vld", 0, ifu_o_pc_vld);
  check_val("reset halt_ack", 0, ifu_halt_ack);
  // Reset fetch goes out one cycle after release
  @(negedge clk);
  check_val("reset req_valid", 1, ifu_req_valid);
  check_val("reset req_pc", RTVEC, ifu_req_pc);
  @(posedge clk);
  #1;
  expect_ir("reset_vector", RTVEC, 0, 0);
endtask

task automatic sequential_fetch();
  logic [31:0] a;
  logic [7:0]  is32;
  is32 = 8'b1001_1011;
  a = 32'h280;
  for (int i = 0; i < 8; i++) begin
    if (is32[i]) begin
      mem_word[a >> 1] = {a[24:0], 7'b0010011};
      a = a + 4;
    end else begin
      mem_word[a >> 1] = {a[15:0], a[13:0], 2'b01};
      a = a + 2;
    end
  end
  apply_flush(32'h280, 32'h0);
  expect_ir("sequential", 32'h280, 0, 0);
  for (int i = 1; i < 8; i++) begin
    // Previous PC plus its length
    expect_ir("sequential", last_pc + step_of(last_ir), 0, 0);
  end
endtask

task automatic halt_and_backpressure();
  int unsigned n;
  logic [31:0] ir_hold;
  logic [31:0] pc_hold;
  n = 0;
  ifu_halt_req = 1'b1;
  @(negedge clk);
  while (!ifu_halt_ack) begin
    n++;
    if (n > TIMEOUT) begin
      $display("Timed out waiting for the halt acknowledge");
      stop_fail();
    end
    @(negedge clk);
  end
  repeat (4) begin
    @(negedge clk);
    check_val("halt req_valid", 0, ifu_req_valid);
    check_val("halt ack held", 1, ifu_halt_ack);
  end
  @(posedge clk);
  #1;
  ifu_halt_req = 1'b0;
  @(negedge clk);
  check_val("halt ack before drop", 1, ifu_halt_ack);
  @(negedge clk);
  check_val("halt ack dropped", 0, ifu_halt_ack);
  // IR must hold still while the execute stage stalls
  wait_o_valid("backpressure");
  ir_hold = ifu_o_ir;
  pc_hold = ifu_o_pc;
  repeat (5) begin
    @(negedge clk);
    check_val("backpressure ir", ir_hold, ifu_o_ir);
    check_val("backpressure pc", pc_hold, ifu_o_pc);
    check_val("backpressure rsp_ready", 0, ifu_rsp_ready);
  end
  @(posedge clk);
  #1;
  expect_ir("after_halt", last_pc + step_of(last_ir), 0, 0);
endtask

task automatic static_prediction();
  mem_word[32'h200 >> 1] = enc_branch(13'd12, 3'b001);
  mem_word[32'h204 >> 1] = 32'h0010_8093;
  mem_word[32'h208 >> 1] = enc_jal(21'h20);
  mem_word[32'h228 >> 1] = enc_branch(-13'sd16, 3'b000);
  apply_flush(32'h200, 32'h0);
  // Forward branch falls through
  expect_ir("fwd_branch", 32'h200, 0, 0);
  expect_ir("predict seq", 32'h204, 0, 0);
  // JAL always redirects
  expect_ir("jal", 32'h208, 1, 0);
  expect_ir("bwd_branch", 32'h208 + 32'h20, 1, 0);
  expect_ir("bwd_target", 32'h228 - 32'h10, 0, 0);
  expect_ir("bwd_next", 32'h21C, 0, 0);
endtask

task automatic bus_error_flag();
  mem_word[32'h300 >> 1] = 32'h0020_8113;
  mem_word[32'h304 >> 1] = 32'h0031_0193;
  mem_word[32'h308 >> 1] = 32'h0041_8213;
  mem_err[32'h304 >> 1]  = 1'b1;
  apply_flush(32'h300, 32'h0);
  expect_ir("buserr before", 32'h300, 0, 0);
  expect_ir("buserr marked", 32'h304, 0, 1);
  expect_ir("buserr after", 32'h308, 0, 0);
endtask

task automatic flush_redirect();
  wait_o_valid("flush");
  @(posedge clk);
  #1;
  check_val("flush ack", 1, pipe_flush_ack);
  // 0x341 + 0x10 with bit 0 cleared
  apply_flush(32'h341, 32'h10);
  @(negedge clk);
  check_val("flush o_valid", 0, ifu_o_valid);
  @(posedge clk);
  #1;
  // Held entry is dropped and the flush target comes first
  expect_ir("flush target", 32'h350, 0, 0);
endtask

`endif

//--- sim/tb_ifu_ifetch.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// Fetch stage testbench
// Clock, reset, DUT, variable latency memory model and test sequence
////////////////////////////////////////////////////////////////////////////

module tb_ifu_ifetch;

  localparam int unsigned TIMEOUT   = 200;
  localparam int unsigned MEM_DEPTH = 512;
  localparam logic [31:0] RTVEC     = 32'h0000_0100;

  logic        clk;
  logic        rst_n;
  logic [31:0] pc_rtvec;
  logic        ifu_req_valid;
  logic        ifu_req_ready;
  logic [31:0] ifu_req_pc;
  logic        ifu_rsp_valid;
  logic        ifu_rsp_ready;
  logic [31:0] ifu_rsp_instr;
  logic        ifu_rsp_err;
  logic        ifu_o_valid;
  logic        ifu_o_ready;
  logic [31:0] ifu_o_ir;
  logic [31:0] ifu_o_pc;
  logic        ifu_o_pc_vld;
  logic        ifu_o_prdt_taken;
  logic        ifu_o_buserr;
  logic        pipe_flush_req;
  logic        pipe_flush_ack;
  logic [31:0] pipe_flush_add_op1;
  logic [31:0] pipe_flush_add_op2;
  logic        ifu_halt_req;
  logic        ifu_halt_ack;

  // One word per halfword address and a bus error mark
  logic [31:0] mem_word [0:MEM_DEPTH-1];
  logic        mem_err  [0:MEM_DEPTH-1];

  // Memory model state
  integer      seed;
  logic        mem_busy;
  int unsigned mem_cnt;
  int unsigned mem_lat;
  logic [31:0] mem_addr;
  logic        req_hsk_s;
  logic        rsp_hsk_s;
  logic [31:0] req_pc_s;

  // Last expected IR entry
  logic [31:0] last_pc;
  logic [31:0] last_ir;

  ifu_ifetch dut (
    .clk                (clk),
    .rst_n              (rst_n),
    .pc_rtvec           (pc_rtvec),
    .ifu_req_valid      (ifu_req_valid),
    .ifu_req_ready      (ifu_req_ready),
    .ifu_req_pc         (ifu_req_pc),
    .ifu_rsp_valid      (ifu_rsp_valid),
    .ifu_rsp_ready      (ifu_rsp_ready),
    .ifu_rsp_instr      (ifu_rsp_instr),
    .ifu_rsp_err        (ifu_rsp_err),
    .ifu_o_valid        (ifu_o_valid),
    .ifu_o_ready        (ifu_o_ready),
    .ifu_o_ir           (ifu_o_ir),
    .ifu_o_pc           (ifu_o_pc),
    .ifu_o_pc_vld       (ifu_o_pc_vld),
    .ifu_o_prdt_taken   (ifu_o_prdt_taken),
    .ifu_o_buserr       (ifu_o_buserr),
    .pipe_flush_req     (pipe_flush_req),
    .pipe_flush_ack     (pipe_flush_ack),
    .pipe_flush_add_op1 (pipe_flush_add_op1),
    .pipe_flush_add_op2 (pipe_flush_add_op2),
    .ifu_halt_req       (ifu_halt_req),
    .ifu_halt_ack       (ifu_halt_ack)
  );

  `include "tb_ifu_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Memory model

  // Handshakes sampled mid-cycle while inputs and flops are settled
  always @(negedge clk) begin
    req_hsk_s = ifu_req_valid & ifu_req_ready;
    rsp_hsk_s = ifu_rsp_valid & ifu_rsp_ready;
    req_pc_s  = ifu_req_pc;
    if (rst_n && req_hsk_s && req_pc_s[0]) begin
      $display("Fetch request address %h is odd", req_pc_s);
      stop_fail();
    end
  end

  // Response and ready change 1 ns after the rising edge
  initial begin
    forever begin
      @(posedge clk);
      #1;
      if (!rst_n) begin
        mem_busy      = 1'b0;
        mem_cnt       = 0;
        ifu_rsp_valid = 1'b0;
      end else begin
        if (rsp_hsk_s) begin
          ifu_rsp_valid = 1'b0;
        end
        if (mem_busy) begin
          mem_cnt = mem_cnt - 1;
          if (mem_cnt == 0) begin
            mem_busy = 1'b0;
            present_rsp(mem_addr);
          end
        end
        if (req_hsk_s) begin
          mem_addr = req_pc_s;
          // Latency of 1 to 3 cycles
          mem_lat  = 1 + ($unsigned($random(seed)) % 3);
          if (mem_lat == 1) begin
            present_rsp(mem_addr);
          end else begin
            mem_busy = 1'b1;
            mem_cnt  = mem_lat - 1;
          end
        end
      end
      ifu_req_ready = ~mem_busy;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    seed               = 24650;
    rst_n              = 1'b0;
    pc_rtvec           = RTVEC;
    ifu_req_ready      = 1'b1;
    ifu_rsp_valid      = 1'b0;
    ifu_rsp_instr      = '0;
    ifu_rsp_err        = 1'b0;
    ifu_o_ready        = 1'b0;
    pipe_flush_req     = 1'b0;
    pipe_flush_add_op1 = '0;
    pipe_flush_add_op2 = '0;
    ifu_halt_req       = 1'b0;
    mem_busy           = 1'b0;
    mem_cnt            = 0;
    mem_addr           = '0;
    last_pc            = '0;
    last_ir            = '0;
    init_memory();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    reset_vector_fetch();
    sequential_fetch();
    halt_and_backpressure();
    static_prediction();
    bus_error_flag();
    flush_redirect();

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- flist.f
+incdir+verilog
+incdir+sim
verilog/rv_isa_pkg.sv
verilog/ifu_pkg.sv
verilog/ifu_minidec.sv
verilog/ifu_litebpu.sv
verilog/ifu_fetch_ctrl.sv
verilog/ifu_pc_gen.sv
verilog/ifu_ir_stage.sv
verilog/ifu_ifetch.sv
sim/tb_ifu_ifetch.sv
